// ==== src/idu_pkg.sv ====
// idu package: rv32im encodings, alu operations and the decode pipeline packets
package idu_pkg;

  localparam int XLEN = 32;

  // major opcodes handled by the decoder
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  typedef enum logic [4:0] {
    ALU_ADD      = 5'd0,
    ALU_SUB      = 5'd1,
    ALU_SLL      = 5'd2,
    ALU_SLT      = 5'd3,
    ALU_SLTU     = 5'd4,
    ALU_XOR      = 5'd5,
    ALU_SRL      = 5'd6,
    ALU_SRA      = 5'd7,
    ALU_OR       = 5'd8,
    ALU_AND      = 5'd9,
    ALU_PASS_IMM = 5'd10,
    ALU_MUL      = 5'd11,
    ALU_MULHU    = 5'd12,
    ALU_DIV      = 5'd13,
    ALU_DIVU     = 5'd14,
    ALU_REM      = 5'd15,
    ALU_REMU     = 5'd16
  } alu_op_e;

  typedef enum logic [1:0] {
    WB_ALU  = 2'd0,
    WB_LOAD = 2'd1,
    WB_PC4  = 2'd2
  } wb_sel_e;

  // funct3 of OP and OP_IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct3 of the M extension
  localparam logic [2:0] F3_MUL    = 3'b000;
  localparam logic [2:0] F3_MULH   = 3'b001;
  localparam logic [2:0] F3_MULHSU = 3'b010;
  localparam logic [2:0] F3_MULHU  = 3'b011;
  localparam logic [2:0] F3_DIV    = 3'b100;
  localparam logic [2:0] F3_DIVU   = 3'b101;
  localparam logic [2:0] F3_REM    = 3'b110;
  localparam logic [2:0] F3_REMU   = 3'b111;

  // branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // access size, low two bits of load/store funct3
  localparam logic [2:0] F3_B = 3'b000;
  localparam logic [2:0] F3_H = 3'b001;
  localparam logic [2:0] F3_W = 3'b010;

  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_ALT    = 7'b0100000;
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
  } fetch_pkt_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] imm;
    alu_op_e         alu_op;
    logic            src1_is_pc;
    logic            src2_is_imm;
    logic            is_branch;
    logic            is_jal;
    logic            is_jalr;
    logic [2:0]      funct3;
    logic [4:0]      rd;
    logic            reg_we;
    logic            mem_re;
    logic            mem_we;
    logic [3:0]      byte_mask;
    logic            mem_signed;
    wb_sel_e         wb_sel;
    logic            illegal;
  } decode_pkt_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] next_pc;
    logic            taken;
    alu_op_e         alu_op;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] store_data;
    logic [4:0]      rd;
    logic            reg_we;
    logic            mem_re;
    logic            mem_we;
    logic [3:0]      byte_mask;
    logic            mem_signed;
    wb_sel_e         wb_sel;
    logic            illegal;
  } issue_pkt_t;

endpackage

// ==== src/fetch_queue.sv ====
// fetch queue: credited input FIFO of fetch packets, one credit back per pop
`timescale 1ns/1ns

module fetch_queue
  import idu_pkg::*;
#(
  parameter int FETCH_DEPTH = 4
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       fetch_valid_i,
  input  fetch_pkt_t fetch_pkt_i,
  input  logic       q_pop_i,
  output logic       q_valid_o,
  output fetch_pkt_t q_pkt_o,
  output logic       fetch_credit_o
);

  localparam int PTR_W = (FETCH_DEPTH > 1) ? $clog2(FETCH_DEPTH) : 1;
  localparam int CNT_W = $clog2(FETCH_DEPTH + 1);

  fetch_pkt_t       mem [FETCH_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;
  logic             full;

  assign push = fetch_valid_i;
  assign pop  = q_pop_i && q_valid_o;
  assign full = (count == CNT_W'(FETCH_DEPTH));

  assign q_valid_o = (count != '0);
  assign q_pkt_o   = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= fetch_pkt_i;
    end
  end

  // pointers wrap at the depth, which need not be a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FETCH_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FETCH_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else begin
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // credit goes back the cycle after the pop
  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_credit_o <= 1'b0;
    end else begin
      fetch_credit_o <= pop;
    end
  end

  // upstream may only send while holding a credit
  a_no_push_when_full: assert property (
    @(posedge clk) disable iff (rst) full |-> !fetch_valid_i
  ) else $error("fetch_queue: push while full, upstream credit violation");

endmodule

// ==== src/decode_stage.sv ====
// decode stage: opcode classification, immediate and control generation, registered
`timescale 1ns/1ns

module decode_stage
  import idu_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        q_valid_i,
  input  fetch_pkt_t  q_pkt_i,
  input  logic        advance_i,
  output logic        q_pop_o,
  output logic        dec_valid_o,
  output decode_pkt_t dec_pkt_o
);

  logic [XLEN-1:0] instr;
  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;
  logic            accept;
  decode_pkt_t     dec_d;

  // shared by OP and OP_IMM, alt only picks sra over srl
  function automatic alu_op_e base_alu(input logic [2:0] f3, input logic alt);
    case (f3)
      F3_ADD:  return ALU_ADD;
      F3_SLL:  return ALU_SLL;
      F3_SLT:  return ALU_SLT;
      F3_SLTU: return ALU_SLTU;
      F3_XOR:  return ALU_XOR;
      F3_SR:   return alt ? ALU_SRA : ALU_SRL;
      F3_OR:   return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic alu_op_e muldiv_alu(input logic [2:0] f3);
    case (f3)
      F3_MULHU: return ALU_MULHU;
      F3_DIV:   return ALU_DIV;
      F3_DIVU:  return ALU_DIVU;
      F3_REM:   return ALU_REM;
      F3_REMU:  return ALU_REMU;
      default:  return ALU_MUL;
    endcase
  endfunction

  function automatic logic [3:0] size_mask(input logic [2:0] f3);
    case ({1'b0, f3[1:0]})
      F3_B:    return 4'b0001;
      F3_H:    return 4'b0011;
      default: return 4'b1111;
    endcase
  endfunction

  assign instr  = q_pkt_i.instr;
  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    dec_d         = '0;
    dec_d.pc      = q_pkt_i.pc;
    dec_d.rs1_val = q_pkt_i.rs1_val;
    dec_d.rs2_val = q_pkt_i.rs2_val;
    dec_d.funct3  = funct3;
    dec_d.rd      = instr[11:7];
    dec_d.alu_op  = ALU_ADD;
    dec_d.wb_sel  = WB_ALU;
    case (opcode)
      OPC_LUI: begin
        dec_d.imm         = imm_u;
        dec_d.alu_op      = ALU_PASS_IMM;
        dec_d.src2_is_imm = 1'b1;
        dec_d.reg_we      = 1'b1;
      end
      OPC_AUIPC: begin
        dec_d.imm         = imm_u;
        dec_d.src1_is_pc  = 1'b1;
        dec_d.src2_is_imm = 1'b1;
        dec_d.reg_we      = 1'b1;
      end
      OPC_JAL: begin
        dec_d.imm         = imm_j;
        dec_d.src1_is_pc  = 1'b1;
        dec_d.src2_is_imm = 1'b1;
        dec_d.is_jal      = 1'b1;
        dec_d.reg_we      = 1'b1;
        dec_d.wb_sel      = WB_PC4;
      end
      OPC_JALR: begin
        dec_d.imm         = imm_i;
        dec_d.src2_is_imm = 1'b1;
        dec_d.is_jalr     = 1'b1;
        dec_d.reg_we      = 1'b1;
        dec_d.wb_sel      = WB_PC4;
      end
      OPC_BRANCH: begin
        dec_d.imm       = imm_b;
        dec_d.is_branch = 1'b1;
        // eq/ne via sub, signed and unsigned compares via slt/sltu
        if (funct3[2] == 1'b0) begin
          dec_d.alu_op = ALU_SUB;
        end else if (funct3[1] == 1'b0) begin
          dec_d.alu_op = ALU_SLT;
        end else begin
          dec_d.alu_op = ALU_SLTU;
        end
      end
      OPC_LOAD: begin
        dec_d.imm         = imm_i;
        dec_d.src2_is_imm = 1'b1;
        dec_d.mem_re      = 1'b1;
        dec_d.reg_we      = 1'b1;
        dec_d.wb_sel      = WB_LOAD;
        dec_d.byte_mask   = size_mask(funct3);
        dec_d.mem_signed  = (funct3 == F3_B) || (funct3 == F3_H);
      end
      OPC_STORE: begin
        dec_d.imm         = imm_s;
        dec_d.src2_is_imm = 1'b1;
        dec_d.mem_we      = 1'b1;
        dec_d.byte_mask   = size_mask(funct3);
      end
      OPC_OP_IMM: begin
        dec_d.imm         = imm_i;
        dec_d.src2_is_imm = 1'b1;
        dec_d.reg_we      = 1'b1;
        dec_d.alu_op      = base_alu(funct3, funct7 == F7_ALT);
      end
      OPC_OP: begin
        case (funct7)
          F7_BASE: dec_d.alu_op = base_alu(funct3, 1'b0);
          F7_ALT: begin
            dec_d.alu_op  = (funct3 == F3_SR) ? ALU_SRA : ALU_SUB;
            dec_d.illegal = (funct3 != F3_ADD) && (funct3 != F3_SR);
          end
          F7_MULDIV: begin
            dec_d.alu_op  = muldiv_alu(funct3);
            // execute has no signed high multiplies
            dec_d.illegal = (funct3 == F3_MULH) || (funct3 == F3_MULHSU);
          end
          default: dec_d.illegal = 1'b1;
        endcase
        dec_d.reg_we = !dec_d.illegal;
      end
      default: dec_d.illegal = 1'b1;
    endcase
  end

  // take a new item when empty or when the current one moves on
  assign accept  = !dec_valid_o || advance_i;
  assign q_pop_o = q_valid_i && accept;

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid_o <= 1'b0;
    end else if (accept) begin
      dec_valid_o <= q_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (q_pop_o) begin
      dec_pkt_o <= dec_d;
    end
  end

endmodule

// ==== src/resolve_stage.sv ====
// resolve stage: alu operand select, branch and jump resolution, credited issue
`timescale 1ns/1ns

module resolve_stage
  import idu_pkg::*;
#(
  parameter int ISSUE_CREDITS = 2
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        dec_valid_i,
  input  decode_pkt_t dec_pkt_i,
  input  logic        issue_credit_i,
  output logic        advance_o,
  output logic        issue_valid_o,
  output issue_pkt_t  issue_pkt_o
);

  localparam int CNT_W = $clog2(ISSUE_CREDITS + 1);

  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] pc_target;
  logic [XLEN-1:0] jalr_sum;
  logic [XLEN-1:0] next_pc;
  logic            br_eq;
  logic            br_lt;
  logic            br_ltu;
  logic            br_cond;
  issue_pkt_t      iss_d;
  logic            hold_valid;
  logic [CNT_W-1:0] credit_cnt;

  assign pc_plus4  = dec_pkt_i.pc + XLEN'(4);
  assign pc_target = dec_pkt_i.pc + dec_pkt_i.imm;
  assign jalr_sum  = dec_pkt_i.rs1_val + dec_pkt_i.imm;

  assign br_eq  = (dec_pkt_i.rs1_val == dec_pkt_i.rs2_val);
  assign br_lt  = ($signed(dec_pkt_i.rs1_val) < $signed(dec_pkt_i.rs2_val));
  assign br_ltu = (dec_pkt_i.rs1_val < dec_pkt_i.rs2_val);

  always_comb begin
    case (dec_pkt_i.funct3)
      F3_BEQ:  br_cond = br_eq;
      F3_BNE:  br_cond = !br_eq;
      F3_BLT:  br_cond = br_lt;
      F3_BGE:  br_cond = !br_lt;
      F3_BLTU: br_cond = br_ltu;
      F3_BGEU: br_cond = !br_ltu;
      default: br_cond = 1'b0;
    endcase
  end

  always_comb begin
    if (dec_pkt_i.is_jalr) begin
      next_pc = {jalr_sum[XLEN-1:1], 1'b0};
    end else if (dec_pkt_i.is_jal || (dec_pkt_i.is_branch && br_cond)) begin
      next_pc = pc_target;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_comb begin
    iss_d.pc         = dec_pkt_i.pc;
    iss_d.next_pc    = next_pc;
    iss_d.taken      = (next_pc != pc_plus4);
    iss_d.alu_op     = dec_pkt_i.alu_op;
    iss_d.src1       = dec_pkt_i.src1_is_pc ? dec_pkt_i.pc : dec_pkt_i.rs1_val;
    iss_d.src2       = dec_pkt_i.src2_is_imm ? dec_pkt_i.imm : dec_pkt_i.rs2_val;
    iss_d.store_data = dec_pkt_i.rs2_val;
    iss_d.rd         = dec_pkt_i.rd;
    iss_d.reg_we     = dec_pkt_i.reg_we;
    iss_d.mem_re     = dec_pkt_i.mem_re;
    iss_d.mem_we     = dec_pkt_i.mem_we;
    iss_d.byte_mask  = dec_pkt_i.byte_mask;
    iss_d.mem_signed = dec_pkt_i.mem_signed;
    iss_d.wb_sel     = dec_pkt_i.wb_sel;
    iss_d.illegal    = dec_pkt_i.illegal;
  end

  // held packet goes out as soon as a credit is available
  assign issue_valid_o = hold_valid && (credit_cnt != '0);
  assign advance_o     = !hold_valid || issue_valid_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      hold_valid <= 1'b0;
    end else if (advance_o) begin
      hold_valid <= dec_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (advance_o && dec_valid_i) begin
      issue_pkt_o <= iss_d;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      credit_cnt <= CNT_W'(ISSUE_CREDITS);
    end else begin
      case ({issue_credit_i, issue_valid_o})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  // execute must not return more credits than it was granted
  a_credit_bound: assert property (
    @(posedge clk) disable iff (rst) credit_cnt <= CNT_W'(ISSUE_CREDITS)
  ) else $error("resolve_stage: issue credit count above %0d", ISSUE_CREDITS);

  // a returned credit needs one outstanding
  a_return_outstanding: assert property (
    @(posedge clk) disable iff (rst)
      issue_credit_i |-> (credit_cnt != CNT_W'(ISSUE_CREDITS)) || issue_valid_o
  ) else $error("resolve_stage: issue credit returned with none outstanding");

endmodule

// ==== src/instr_decode_unit.sv ====
// instruction decode unit: fetch queue, decode and resolve stages with credit flow
`timescale 1ns/1ns

module instr_decode_unit
  import idu_pkg::*;
#(
  parameter int FETCH_DEPTH   = 4,
  parameter int ISSUE_CREDITS = 2
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       fetch_valid_i,
  input  fetch_pkt_t fetch_pkt_i,
  input  logic       issue_credit_i,
  output logic       fetch_credit_o,
  output logic       issue_valid_o,
  output issue_pkt_t issue_pkt_o
);

  logic        q_valid;
  fetch_pkt_t  q_pkt;
  logic        q_pop;
  logic        dec_valid;
  decode_pkt_t dec_pkt;
  logic        dec_advance;

  fetch_queue #(
    .FETCH_DEPTH(FETCH_DEPTH)
  ) fetch_queue_inst (
    .clk            (clk),
    .rst            (rst),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_pkt_i    (fetch_pkt_i),
    .q_pop_i        (q_pop),
    .q_valid_o      (q_valid),
    .q_pkt_o        (q_pkt),
    .fetch_credit_o (fetch_credit_o)
  );

  decode_stage decode_stage_inst (
    .clk         (clk),
    .rst         (rst),
    .q_valid_i   (q_valid),
    .q_pkt_i     (q_pkt),
    .advance_i   (dec_advance),
    .q_pop_o     (q_pop),
    .dec_valid_o (dec_valid),
    .dec_pkt_o   (dec_pkt)
  );

  resolve_stage #(
    .ISSUE_CREDITS(ISSUE_CREDITS)
  ) resolve_stage_inst (
    .clk            (clk),
    .rst            (rst),
    .dec_valid_i    (dec_valid),
    .dec_pkt_i      (dec_pkt),
    .issue_credit_i (issue_credit_i),
    .advance_o      (dec_advance),
    .issue_valid_o  (issue_valid_o),
    .issue_pkt_o    (issue_pkt_o)
  );

endmodule

// ==== include/tb_vectors.svh ====
// decode unit test vectors: fetch packets with the issue fields expected for each
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam int NUM_ROWS = 33;

typedef struct packed {
  fetch_pkt_t  fetch;
  alu_op_e     alu_op;
  logic [31:0] src1;
  logic [31:0] src2;
  logic [4:0]  rd;
  // reg_we, mem_re, mem_we
  logic [2:0]  flags;
  logic [3:0]  byte_mask;
  logic        mem_signed;
  wb_sel_e     wb_sel;
  logic [31:0] next_pc;
  logic        taken;
  logic        illegal;
} vec_row_t;

vec_row_t vectors [NUM_ROWS];
int       row_count = 0;

task automatic add_row(
  input logic [31:0] pc,
  input logic [31:0] instr,
  input logic [31:0] rs1_val,
  input logic [31:0] rs2_val,
  input logic [4:0]  rd,
  input alu_op_e     alu_op,
  input logic [31:0] src1,
  input logic [31:0] src2,
  input logic [2:0]  flags,
  input logic [3:0]  byte_mask,
  input logic        mem_signed,
  input wb_sel_e     wb_sel,
  input logic [31:0] next_pc,
  input logic        taken,
  input logic        illegal
);
  vectors[row_count] = {pc, instr, rs1_val, rs2_val, alu_op, src1, src2, rd, flags,
                        byte_mask, mem_signed, wb_sel, next_pc, taken, illegal};
  row_count++;
endtask

// columns: pc, instr, rs1_val, rs2_val, rd, then alu_op, src1, src2, flags,
// byte_mask, mem_signed, wb_sel, next_pc, taken, illegal
task automatic load_vectors();
  // register and M ops
  add_row('h00001000, 'h002081b3, 'h00000005, 'h00000007, 5'd3,
    ALU_ADD, 'h00000005, 'h00000007, 3'b100, 4'h0, 0, WB_ALU, 'h00001004, 0, 0);
  add_row('h00001004, 'h40208233, 'h00000009, 'h00000004, 5'd4,
    ALU_SUB, 'h00000009, 'h00000004, 3'b100, 4'h0, 0, WB_ALU, 'h00001008, 0, 0);
  add_row('h00001008, 'h4020d2b3, 'hf0000000, 'h00000004, 5'd5,
    ALU_SRA, 'hf0000000, 'h00000004, 3'b100, 4'h0, 0, WB_ALU, 'h0000100c, 0, 0);
  add_row('h0000100c, 'h02208333, 'h00000006, 'h00000007, 5'd6,
    ALU_MUL, 'h00000006, 'h00000007, 3'b100, 4'h0, 0, WB_ALU, 'h00001010, 0, 0);
  add_row('h00001010, 'h0220d3b3, 'h00000064, 'h0000000a, 5'd7,
    ALU_DIVU, 'h00000064, 'h0000000a, 3'b100, 4'h0, 0, WB_ALU, 'h00001014, 0, 0);
  add_row('h00001014, 'h0220f433, 'h00000064, 'h00000007, 5'd8,
    ALU_REMU, 'h00000064, 'h00000007, 3'b100, 4'h0, 0, WB_ALU, 'h00001018, 0, 0);
  // immediate ops
  add_row('h00001018, 'hffd08493, 'h00000010, 'h00000000, 5'd9,
    ALU_ADD, 'h00000010, 'hfffffffd, 3'b100, 4'h0, 0, WB_ALU, 'h0000101c, 0, 0);
  add_row('h0000101c, 'h0050b513, 'h00000003, 'h00000000, 5'd10,
    ALU_SLTU, 'h00000003, 'h00000005, 3'b100, 4'h0, 0, WB_ALU, 'h00001020, 0, 0);
  add_row('h00001020, 'h4040d593, 'h80000000, 'h00000000, 5'd11,
    ALU_SRA, 'h80000000, 'h00000404, 3'b100, 4'h0, 0, WB_ALU, 'h00001024, 0, 0);
  add_row('h00001024, 'h00309613, 'h00000001, 'h00000000, 5'd12,
    ALU_SLL, 'h00000001, 'h00000003, 3'b100, 4'h0, 0, WB_ALU, 'h00001028, 0, 0);
  add_row('h00001028, 'h123456b7, 'h00000000, 'h00000000, 5'd13,
    ALU_PASS_IMM, 'h00000000, 'h12345000, 3'b100, 4'h0, 0, WB_ALU, 'h0000102c, 0, 0);
  add_row('h0000102c, 'h00001717, 'h00000000, 'h00000000, 5'd14,
    ALU_ADD, 'h0000102c, 'h00001000, 3'b100, 4'h0, 0, WB_ALU, 'h00001030, 0, 0);
  // sb with a negative split offset, then the five loads
  add_row('h00001030, 'hfe208e23, 'h00004000, 'h000000ab, 5'd28,
    ALU_ADD, 'h00004000, 'hfffffffc, 3'b001, 4'h1, 0, WB_ALU, 'h00001034, 0, 0);
  add_row('h00001034, 'h00408783, 'h00004000, 'h00000000, 5'd15,
    ALU_ADD, 'h00004000, 'h00000004, 3'b110, 4'h1, 1, WB_LOAD, 'h00001038, 0, 0);
  add_row('h00001038, 'h00409803, 'h00004000, 'h00000000, 5'd16,
    ALU_ADD, 'h00004000, 'h00000004, 3'b110, 4'h3, 1, WB_LOAD, 'h0000103c, 0, 0);
  add_row('h0000103c, 'h0040a883, 'h00004000, 'h00000000, 5'd17,
    ALU_ADD, 'h00004000, 'h00000004, 3'b110, 4'hf, 0, WB_LOAD, 'h00001040, 0, 0);
  add_row('h00001040, 'h0040c903, 'h00004000, 'h00000000, 5'd18,
    ALU_ADD, 'h00004000, 'h00000004, 3'b110, 4'h1, 0, WB_LOAD, 'h00001044, 0, 0);
  add_row('h00001044, 'h0040d983, 'h00004000, 'h00000000, 5'd19,
    ALU_ADD, 'h00004000, 'h00000004, 3'b110, 4'h3, 0, WB_LOAD, 'h00001048, 0, 0);
  // branches, taken then not taken for each condition
  add_row('h00001048, 'hfe208ce3, 'h00000005, 'h00000005, 5'd25,
    ALU_SUB, 'h00000005, 'h00000005, 3'b000, 4'h0, 0, WB_ALU, 'h00001040, 1, 0);
  add_row('h0000104c, 'h00208863, 'h00000005, 'h00000006, 5'd16,
    ALU_SUB, 'h00000005, 'h00000006, 3'b000, 4'h0, 0, WB_ALU, 'h00001050, 0, 0);
  add_row('h00001050, 'h00209863, 'h00000005, 'h00000006, 5'd16,
    ALU_SUB, 'h00000005, 'h00000006, 3'b000, 4'h0, 0, WB_ALU, 'h00001060, 1, 0);
  add_row('h00001054, 'h00209863, 'h00000005, 'h00000005, 5'd16,
    ALU_SUB, 'h00000005, 'h00000005, 3'b000, 4'h0, 0, WB_ALU, 'h00001058, 0, 0);
  add_row('h00001058, 'h0020c863, 'hffffffff, 'h00000001, 5'd16,
    ALU_SLT, 'hffffffff, 'h00000001, 3'b000, 4'h0, 0, WB_ALU, 'h00001068, 1, 0);
  add_row('h0000105c, 'h0020c863, 'h00000001, 'hffffffff, 5'd16,
    ALU_SLT, 'h00000001, 'hffffffff, 3'b000, 4'h0, 0, WB_ALU, 'h00001060, 0, 0);
  add_row('h00001060, 'h0020d863, 'h00000001, 'hffffffff, 5'd16,
    ALU_SLT, 'h00000001, 'hffffffff, 3'b000, 4'h0, 0, WB_ALU, 'h00001070, 1, 0);
  add_row('h00001064, 'h0020d863, 'hffffffff, 'h00000001, 5'd16,
    ALU_SLT, 'hffffffff, 'h00000001, 3'b000, 4'h0, 0, WB_ALU, 'h00001068, 0, 0);
  add_row('h00001068, 'h0020e863, 'h00000001, 'hffffffff, 5'd16,
    ALU_SLTU, 'h00000001, 'hffffffff, 3'b000, 4'h0, 0, WB_ALU, 'h00001078, 1, 0);
  add_row('h0000106c, 'h0020e863, 'hffffffff, 'h00000001, 5'd16,
    ALU_SLTU, 'hffffffff, 'h00000001, 3'b000, 4'h0, 0, WB_ALU, 'h00001070, 0, 0);
  add_row('h00001070, 'h0020f863, 'hffffffff, 'h00000001, 5'd16,
    ALU_SLTU, 'hffffffff, 'h00000001, 3'b000, 4'h0, 0, WB_ALU, 'h00001080, 1, 0);
  add_row('h00001074, 'h0020f863, 'h00000001, 'hffffffff, 5'd16,
    ALU_SLTU, 'h00000001, 'hffffffff, 3'b000, 4'h0, 0, WB_ALU, 'h00001078, 0, 0);
  // jal, jalr with odd sum, unknown opcode
  add_row('h00001078, 'h100000ef, 'h00000000, 'h00000000, 5'd1,
    ALU_ADD, 'h00001078, 'h00000100, 3'b100, 4'h0, 0, WB_PC4, 'h00001178, 1, 0);
  add_row('h0000107c, 'h007100e7, 'h00002000, 'h00000000, 5'd1,
    ALU_ADD, 'h00002000, 'h00000007, 3'b100, 4'h0, 0, WB_PC4, 'h00002006, 1, 0);
  add_row('h00001080, 'h0000000b, 'h00000011, 'h00000022, 5'd0,
    ALU_ADD, 'h00000011, 'h00000022, 3'b000, 4'h0, 0, WB_ALU, 'h00001084, 0, 1);
endtask

`endif

// ==== tb/tb_instr_decode_unit.sv ====
// testbench for the instruction decode unit: table driven with credits on both sides
`timescale 1ns/1ns

module tb_instr_decode_unit
  import idu_pkg::*;
();

  localparam int FETCH_DEPTH   = 4;
  localparam int ISSUE_CREDITS = 2;

  logic       clk;
  logic       rst;
  logic       fetch_valid_i;
  fetch_pkt_t fetch_pkt_i;
  logic       issue_credit_i;
  logic       fetch_credit_o;
  logic       issue_valid_o;
  issue_pkt_t issue_pkt_o;

  integer seed;
  int     cycle = 0;
  int     sent_count = 0;
  int     recv_count = 0;
  int     fetch_credit_count = 0;
  int     error_count = 0;
  int     up_credits = FETCH_DEPTH;
  int     dn_credits = ISSUE_CREDITS;
  int     first_send_cycle = -1;
  int     return_due [$];

  `include "tb_vectors.svh"

  localparam int CYCLE_LIMIT = 20 * NUM_ROWS + 50;

  instr_decode_unit #(
    .FETCH_DEPTH  (FETCH_DEPTH),
    .ISSUE_CREDITS(ISSUE_CREDITS)
  ) instr_decode_unit_inst (
    .clk            (clk),
    .rst            (rst),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_pkt_i    (fetch_pkt_i),
    .issue_credit_i (issue_credit_i),
    .fetch_credit_o (fetch_credit_o),
    .issue_valid_o  (issue_valid_o),
    .issue_pkt_o    (issue_pkt_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic check_field(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("error: %0t %s expected %h got %h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_packet(input int idx);
    vec_row_t v;
    v = vectors[idx];
    check_field("issue_pkt_o.pc", v.fetch.pc, issue_pkt_o.pc);
    check_field("issue_pkt_o.next_pc", v.next_pc, issue_pkt_o.next_pc);
    check_field("issue_pkt_o.taken", v.taken, issue_pkt_o.taken);
    check_field("issue_pkt_o.alu_op", v.alu_op, issue_pkt_o.alu_op);
    check_field("issue_pkt_o.src1", v.src1, issue_pkt_o.src1);
    check_field("issue_pkt_o.src2", v.src2, issue_pkt_o.src2);
    check_field("issue_pkt_o.store_data", v.fetch.rs2_val, issue_pkt_o.store_data);
    check_field("issue_pkt_o.rd", v.rd, issue_pkt_o.rd);
    check_field("issue_pkt_o.reg_we", v.flags[2], issue_pkt_o.reg_we);
    check_field("issue_pkt_o.mem_re", v.flags[1], issue_pkt_o.mem_re);
    check_field("issue_pkt_o.mem_we", v.flags[0], issue_pkt_o.mem_we);
    check_field("issue_pkt_o.byte_mask", v.byte_mask, issue_pkt_o.byte_mask);
    check_field("issue_pkt_o.mem_signed", v.mem_signed, issue_pkt_o.mem_signed);
    check_field("issue_pkt_o.wb_sel", v.wb_sel, issue_pkt_o.wb_sel);
    check_field("issue_pkt_o.illegal", v.illegal, issue_pkt_o.illegal);
  endtask

  task automatic take_packet();
    int unsigned delay;
    if (dn_credits == 0) begin
      $display("issue_valid_o rose at %0t with no issue credit outstanding", $time);
      error_count++;
    end else begin
      dn_credits--;
    end
    if (recv_count >= NUM_ROWS) begin
      $display("extra packet issued at %0t after all rows came out", $time);
      error_count++;
    end else begin
      check_packet(recv_count);
    end
    // empty pipe with credits: valid after the third edge from the send
    if (recv_count == 0 && cycle != first_send_cycle + 3) begin
      $display("error: %0t first issue_valid_o cycle expected %0d got %0d",
               $time, first_send_cycle + 3, cycle);
      error_count++;
    end
    delay = $unsigned($random(seed)) % 4;
    return_due.push_back(cycle + delay);
    recv_count++;
  endtask

  always @(negedge clk) begin
    if (rst !== 1'b0) begin
      if (cycle > 0 && (issue_valid_o !== 1'b0 || fetch_credit_o !== 1'b0)) begin
        $display("outputs not idle during reset at %0t", $time);
        error_count++;
      end
    end else begin
      if (fetch_credit_o) begin
        fetch_credit_count++;
        up_credits++;
        if (up_credits > FETCH_DEPTH) begin
          $display("more fetch credits returned than packets sent at %0t", $time);
          error_count++;
        end
      end
      if (issue_valid_o) begin
        take_packet();
      end
      // a return in flight is counted by the DUT at the next edge
      if (issue_credit_i) begin
        dn_credits++;
      end
    end
  end

  task automatic drive_fetch();
    if (sent_count < NUM_ROWS && up_credits > 0) begin
      fetch_valid_i = 1'b1;
      fetch_pkt_i   = vectors[sent_count].fetch;
      if (sent_count == 0) begin
        first_send_cycle = cycle;
      end
      sent_count++;
      up_credits--;
    end else begin
      fetch_valid_i = 1'b0;
    end
  endtask

  task automatic return_credit();
    if (return_due.size() > 0 && return_due[0] <= cycle) begin
      issue_credit_i = 1'b1;
      void'(return_due.pop_front());
    end else begin
      issue_credit_i = 1'b0;
    end
  endtask

  initial begin
    seed           = 77;
    rst            = 1'b1;
    fetch_valid_i  = 1'b0;
    fetch_pkt_i    = '0;
    issue_credit_i = 1'b0;
    load_vectors();
    if (row_count != NUM_ROWS) begin
      $display("vector table holds %0d rows instead of %0d", row_count, NUM_ROWS);
      error_count++;
    end
    repeat (3) @(posedge clk);
    #10;
    rst = 1'b0;
    while (recv_count < NUM_ROWS && cycle < CYCLE_LIMIT) begin
      drive_fetch();
      return_credit();
      @(posedge clk);
      #10;
    end
    fetch_valid_i = 1'b0;
    // hand back the credits still pending
    repeat (6) begin
      return_credit();
      @(posedge clk);
      #10;
    end
    issue_credit_i = 1'b0;
    if (recv_count < NUM_ROWS) begin
      $display("timeout after %0d cycles with %0d of %0d packets issued",
               cycle, recv_count, NUM_ROWS);
      error_count++;
    end
    if (fetch_credit_count != sent_count) begin
      $display("fetch credits returned %0d but rows sent %0d", fetch_credit_count, sent_count);
      error_count++;
    end
    if (dn_credits != ISSUE_CREDITS) begin
      $display("issue credit count ended at %0d instead of %0d", dn_credits, ISSUE_CREDITS);
      error_count++;
    end
    $display("sent %0d, issued %0d, fetch credits %0d, errors %0d",
             sent_count, recv_count, fetch_credit_count, error_count);
    if (error_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== instr_decode_unit.f ====
+incdir+include
src/idu_pkg.sv
src/fetch_queue.sv
src/decode_stage.sv
src/resolve_stage.sv
src/instr_decode_unit.sv
tb/tb_instr_decode_unit.sv
